// ==== enigma_pkg.sv ====
package enigma_pkg;

    // letters A to Z
    localparam int ALPHABET_SIZE = 26;

    // letter index, 0 is A
    typedef logic [4:0] letter_t;

    // ascii code of A, offset of the ciphertext byte
    localparam logic [7:0] ASCII_A = 8'h41;

    ////////////////////////////////////////
    // wiring tables
    ////////////////////////////////////////

    // index is the rotor number, 3 is the fast rotor
    // 1 = rotor I, 2 = rotor II, 3 = rotor III
    localparam letter_t ROTOR_WIRING [1:3][0:25] = '{
        // EKMFLGDQVZNTOWYHXUSPAIBRCJ
        '{5'd4,  5'd10, 5'd12, 5'd5,  5'd11, 5'd6,  5'd3,  5'd16, 5'd21,
          5'd25, 5'd13, 5'd19, 5'd14, 5'd22, 5'd24, 5'd7,  5'd23, 5'd20,
          5'd18, 5'd15, 5'd0,  5'd8,  5'd1,  5'd17, 5'd2,  5'd9},
        // AJDKSIRUXBLHWTMCQGZNPYFVOE
        '{5'd0,  5'd9,  5'd3,  5'd10, 5'd18, 5'd8,  5'd17, 5'd20, 5'd23,
          5'd1,  5'd11, 5'd7,  5'd22, 5'd19, 5'd12, 5'd2,  5'd16, 5'd6,
          5'd25, 5'd13, 5'd15, 5'd24, 5'd5,  5'd21, 5'd14, 5'd4},
        // BDFHJLCPRTXVZNYEIWGAKMUSQO
        '{5'd1,  5'd3,  5'd5,  5'd7,  5'd9,  5'd11, 5'd2,  5'd15, 5'd17,
          5'd19, 5'd23, 5'd21, 5'd25, 5'd13, 5'd24, 5'd4,  5'd8,  5'd22,
          5'd6,  5'd0,  5'd10, 5'd12, 5'd20, 5'd18, 5'd16, 5'd14}
    };

    // turnover letters Q, E, V
    localparam letter_t ROTOR_NOTCH [1:3] = '{5'd16, 5'd4, 5'd21};

    // reflector B, YRUHQSLDPXNGOKMIEBFZCWVJAT
    localparam letter_t REFLECTOR_WIRING [0:25] = '{
        5'd24, 5'd17, 5'd20, 5'd7,  5'd16, 5'd18, 5'd11, 5'd3,  5'd15,
        5'd23, 5'd13, 5'd6,  5'd14, 5'd10, 5'd12, 5'd8,  5'd4,  5'd1,
        5'd5,  5'd25, 5'd2,  5'd22, 5'd21, 5'd9,  5'd0,  5'd19
    };

    // a + b modulo 26, both inputs already below 26
    function automatic letter_t letter_add(input letter_t a, input letter_t b);
        logic [5:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= 6'(ALPHABET_SIZE)) begin
            sum = sum - 6'(ALPHABET_SIZE);
        end
        return sum[4:0];
    endfunction

endpackage

// ==== board_pkg.sv ====
package board_pkg;

    // keyboard set 2 release prefix
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // board switch and push key widths
    localparam int SW_WIDTH  = 10;
    localparam int KEY_WIDTH = 4;

    ////////////////////////////////////////
    // setting select switch words
    ////////////////////////////////////////

    // exactly one switch up selects a field
    // bits 1, 4 and 7 picked rotor numbers on the board, unused here
    localparam logic [SW_WIDTH-1:0] SEL_START3 = 10'b00_0000_0001;
    localparam logic [SW_WIDTH-1:0] SEL_RING2  = 10'b00_0000_0100;
    localparam logic [SW_WIDTH-1:0] SEL_START2 = 10'b00_0000_1000;
    localparam logic [SW_WIDTH-1:0] SEL_RING1  = 10'b00_0010_0000;
    localparam logic [SW_WIDTH-1:0] SEL_START1 = 10'b00_0100_0000;

    // seven segment pattern, bit 0 is segment a, bit 6 is g
    // active low, a 0 lights the segment
    typedef logic [6:0] glyph_t;

    // all segments dark
    localparam glyph_t GLYPH_BLANK = 7'h7F;

endpackage

// ==== settings_control.sv ====
`timescale 1ns/1ps

module settings_control (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic [board_pkg::SW_WIDTH-1:0]  i_sw,
    input  logic [board_pkg::KEY_WIDTH-1:0] i_key,
    output enigma_pkg::letter_t             o_start3,
    output enigma_pkg::letter_t             o_start2,
    output enigma_pkg::letter_t             o_start1,
    output enigma_pkg::letter_t             o_ring2,
    output enigma_pkg::letter_t             o_ring1,
    output logic                            o_reload,
    output logic [4:0]                      o_led_select
);

    logic [board_pkg::SW_WIDTH-1:0]  sw_meta;
    logic [board_pkg::SW_WIDTH-1:0]  sw_sync;
    logic [board_pkg::KEY_WIDTH-1:0] key_meta;
    logic [board_pkg::KEY_WIDTH-1:0] key_sync;
    logic                            key3_prev;
    logic                            press;
    logic [4:0]                      sel;

    ////////////////////////////////////////
    // input synchronizers
    ////////////////////////////////////////

    // keys idle high, so reset to ones to avoid a false press
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sw_meta   <= '0;
            sw_sync   <= '0;
            key_meta  <= '1;
            key_sync  <= '1;
            key3_prev <= 1'b1;
        end else begin
            sw_meta   <= i_sw;
            sw_sync   <= sw_meta;
            key_meta  <= i_key;
            key_sync  <= key_meta;
            key3_prev <= key_sync[3];
        end
    end

    // falling edge of key 3
    assign press = key3_prev && !key_sync[3];

    // one-hot field select, bit 0 start3 up to bit 4 start1
    assign sel[0] = (sw_sync == board_pkg::SEL_START3);
    assign sel[1] = (sw_sync == board_pkg::SEL_RING2);
    assign sel[2] = (sw_sync == board_pkg::SEL_START2);
    assign sel[3] = (sw_sync == board_pkg::SEL_RING1);
    assign sel[4] = (sw_sync == board_pkg::SEL_START1);

    assign o_led_select = sel;

    ////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_start3 <= '0;
            o_start2 <= '0;
            o_start1 <= '0;
            o_ring2  <= '0;
            o_ring1  <= '0;
            o_reload <= 1'b0;
        end else begin
            // pulse alongside the new value, positions load next edge
            o_reload <= press && (|sel);
            if (press && sel[0]) begin
                o_start3 <= enigma_pkg::letter_add(o_start3, 5'd1);
            end
            if (press && sel[1]) begin
                o_ring2 <= enigma_pkg::letter_add(o_ring2, 5'd1);
            end
            if (press && sel[2]) begin
                o_start2 <= enigma_pkg::letter_add(o_start2, 5'd1);
            end
            if (press && sel[3]) begin
                o_ring1 <= enigma_pkg::letter_add(o_ring1, 5'd1);
            end
            if (press && sel[4]) begin
                o_start1 <= enigma_pkg::letter_add(o_start1, 5'd1);
            end
        end
    end

endmodule

// ==== keystroke_fsm.sv ====
`timescale 1ns/1ps

module keystroke_fsm #(
    parameter int RELEASE_HOLD_CYCLES = 5000
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic [7:0]          i_scan_code,
    input  logic                i_scan_valid,
    input  enigma_pkg::letter_t i_cipher,
    output enigma_pkg::letter_t o_letter,
    output logic                o_letter_ok,
    output logic                o_rotate,
    output logic [7:0]          o_cipher_ascii
);

    localparam int CNT_W = $clog2(RELEASE_HOLD_CYCLES + 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_MAKE  = 2'd1;
    localparam logic [1:0] ST_BREAK = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    logic [1:0]       state;
    logic [7:0]       history;
    logic [CNT_W-1:0] hold_cnt;
    logic             break_seen;
    logic             release_seen;

    assign break_seen   = i_scan_valid && (i_scan_code == board_pkg::BREAK_CODE);
    assign release_seen = i_scan_valid && (i_scan_code == history);

    // set 2 scan code to letter, anything else is not a letter
    always_comb begin
        o_letter_ok = 1'b1;
        case (history)
            8'h1C: o_letter = 5'd0;
            8'h32: o_letter = 5'd1;
            8'h21: o_letter = 5'd2;
            8'h23: o_letter = 5'd3;
            8'h24: o_letter = 5'd4;
            8'h2B: o_letter = 5'd5;
            8'h34: o_letter = 5'd6;
            8'h33: o_letter = 5'd7;
            8'h43: o_letter = 5'd8;
            8'h3B: o_letter = 5'd9;
            8'h42: o_letter = 5'd10;
            8'h4B: o_letter = 5'd11;
            8'h3A: o_letter = 5'd12;
            8'h31: o_letter = 5'd13;
            8'h44: o_letter = 5'd14;
            8'h4D: o_letter = 5'd15;
            8'h15: o_letter = 5'd16;
            8'h2D: o_letter = 5'd17;
            8'h1B: o_letter = 5'd18;
            8'h2C: o_letter = 5'd19;
            8'h3C: o_letter = 5'd20;
            8'h2A: o_letter = 5'd21;
            8'h1D: o_letter = 5'd22;
            8'h22: o_letter = 5'd23;
            8'h35: o_letter = 5'd24;
            8'h1A: o_letter = 5'd25;
            default: begin
                o_letter    = 5'd0;
                o_letter_ok = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////
    // make / break sequencing
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= ST_IDLE;
            history        <= 8'h00;
            hold_cnt       <= '0;
            o_rotate       <= 1'b0;
            o_cipher_ascii <= 8'h00;
        end else begin
            // rotate and ciphertext default low
            o_rotate       <= 1'b0;
            o_cipher_ascii <= 8'h00;
            case (state)
                ST_IDLE: begin
                    if (i_scan_valid) begin
                        state   <= ST_MAKE;
                        history <= i_scan_code;
                    end
                end
                ST_MAKE: begin
                    // typematic repeats of the held key fall through here
                    if (break_seen) begin
                        state <= ST_BREAK;
                    end else if (o_letter_ok) begin
                        o_cipher_ascii <= {3'b000, i_cipher} + enigma_pkg::ASCII_A;
                    end
                end
                ST_BREAK: begin
                    // release of some other key keeps waiting
                    if (release_seen) begin
                        state    <= ST_WAIT;
                        hold_cnt <= '0;
                        o_rotate <= o_letter_ok;
                    end
                end
                ST_WAIT: begin
                    if (hold_cnt == CNT_W'(RELEASE_HOLD_CYCLES)) begin
                        state <= ST_IDLE;
                    end
                    hold_cnt <= hold_cnt + CNT_W'(1);
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== rotor_stepper.sv ====
`timescale 1ns/1ps

module rotor_stepper (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rotate,
    input  logic                i_reload,
    input  enigma_pkg::letter_t i_start3,
    input  enigma_pkg::letter_t i_start2,
    input  enigma_pkg::letter_t i_start1,
    output enigma_pkg::letter_t o_pos3,
    output enigma_pkg::letter_t o_pos2,
    output enigma_pkg::letter_t o_pos1
);

    logic notch3;
    logic notch2;

    // notch state before the step
    assign notch3 = (o_pos3 == enigma_pkg::ROTOR_NOTCH[3]);
    assign notch2 = (o_pos2 == enigma_pkg::ROTOR_NOTCH[2]);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pos3 <= '0;
            o_pos2 <= '0;
            o_pos1 <= '0;
        end else if (i_reload) begin
            // reload beats a rotate in the same cycle
            o_pos3 <= i_start3;
            o_pos2 <= i_start2;
            o_pos1 <= i_start1;
        end else if (i_rotate) begin
            // fast rotor every keystroke
            o_pos3 <= enigma_pkg::letter_add(o_pos3, 5'd1);
            // middle rotor carries or steps itself off its notch
            if (notch3 || notch2) begin
                o_pos2 <= enigma_pkg::letter_add(o_pos2, 5'd1);
            end
            // slow rotor, together with the middle one gives the double step
            if (notch2) begin
                o_pos1 <= enigma_pkg::letter_add(o_pos1, 5'd1);
            end
        end
    end

endmodule

// ==== cipher_path.sv ====
`timescale 1ns/1ps

module cipher_path (
    input  enigma_pkg::letter_t i_letter,
    input  enigma_pkg::letter_t i_pos3,
    input  enigma_pkg::letter_t i_pos2,
    input  enigma_pkg::letter_t i_pos1,
    input  enigma_pkg::letter_t i_ring2,
    input  enigma_pkg::letter_t i_ring1,
    output enigma_pkg::letter_t o_cipher
);

    enigma_pkg::letter_t off2;
    enigma_pkg::letter_t off1;
    enigma_pkg::letter_t fwd3;
    enigma_pkg::letter_t fwd2;
    enigma_pkg::letter_t fwd1;
    enigma_pkg::letter_t refl;
    enigma_pkg::letter_t back1;
    enigma_pkg::letter_t back2;

    // a - b modulo 26
    function automatic enigma_pkg::letter_t letter_sub(input enigma_pkg::letter_t a,
                                                       input enigma_pkg::letter_t b);
        logic [5:0] diff;
        diff = {1'b0, a} + 6'(enigma_pkg::ALPHABET_SIZE) - {1'b0, b};
        // sum spans 1 to 51, one wrap brings it below 26
        if (diff >= 6'(enigma_pkg::ALPHABET_SIZE)) begin
            diff = diff - 6'(enigma_pkg::ALPHABET_SIZE);
        end
        return diff[4:0];
    endfunction

    // entry contact shifted by the offset, then back out
    function automatic enigma_pkg::letter_t rotor_fwd(input int r,
                                                      input enigma_pkg::letter_t x,
                                                      input enigma_pkg::letter_t off);
        return letter_sub(enigma_pkg::ROTOR_WIRING[r][enigma_pkg::letter_add(x, off)], off);
    endfunction

    // return path, search the forward table for the contact
    function automatic enigma_pkg::letter_t rotor_inv(input int r,
                                                      input enigma_pkg::letter_t x,
                                                      input enigma_pkg::letter_t off);
        enigma_pkg::letter_t contact;
        enigma_pkg::letter_t found;
        contact = enigma_pkg::letter_add(x, off);
        found   = 5'd0;
        for (int j = 0; j < enigma_pkg::ALPHABET_SIZE; j++) begin
            if (enigma_pkg::ROTOR_WIRING[r][j] == contact) begin
                found = 5'(j);
            end
        end
        return letter_sub(found, off);
    endfunction

    // fast rotor has ring A, its offset is the position itself
    assign off2 = letter_sub(i_pos2, i_ring2);
    assign off1 = letter_sub(i_pos1, i_ring1);

    ////////////////////////////////////////
    // forward, reflect, back
    ////////////////////////////////////////

    assign fwd3     = rotor_fwd(3, i_letter, i_pos3);
    assign fwd2     = rotor_fwd(2, fwd3, off2);
    assign fwd1     = rotor_fwd(1, fwd2, off1);
    assign refl     = enigma_pkg::REFLECTOR_WIRING[fwd1];
    assign back1    = rotor_inv(1, refl, off1);
    assign back2    = rotor_inv(2, back1, off2);
    assign o_cipher = rotor_inv(3, back2, i_pos3);

endmodule

// ==== display_driver.sv ====
`timescale 1ns/1ps

module display_driver (
    input  enigma_pkg::letter_t i_letter,
    input  logic                i_letter_ok,
    input  logic [7:0]          i_cipher_ascii,
    input  enigma_pkg::letter_t i_pos3,
    output board_pkg::glyph_t   o_hex0,
    output board_pkg::glyph_t   o_hex1,
    output board_pkg::glyph_t   o_hex2,
    output board_pkg::glyph_t   o_hex3,
    output board_pkg::glyph_t   o_hex4,
    output board_pkg::glyph_t   o_hex5
);

    // letter shapes, some only approximate on seven segments
    // K, M, W and X borrow the nearest shape
    localparam board_pkg::glyph_t LETTER_GLYPH [0:25] = '{
        7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E, 7'h42,
        7'h09, 7'h4F, 7'h61, 7'h0A, 7'h47, 7'h6A, 7'h2B,
        7'h23, 7'h0C, 7'h18, 7'h2F, 7'h12, 7'h07, 7'h41,
        7'h63, 7'h55, 7'h09, 7'h11, 7'h24
    };

    // hex digits 0 to F
    localparam board_pkg::glyph_t HEX_GLYPH [0:15] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    enigma_pkg::letter_t cipher_idx;

    // ascii back to a letter index
    assign cipher_idx = 5'(i_cipher_ascii - enigma_pkg::ASCII_A);

    ////////////////////////////////////////
    // digit mapping
    ////////////////////////////////////////

    // plaintext on the right digit
    assign o_hex0 = i_letter_ok ? LETTER_GLYPH[i_letter] : board_pkg::GLYPH_BLANK;

    // zero byte means no ciphertext shown
    assign o_hex2 = (i_cipher_ascii != 8'h00) ? LETTER_GLYPH[cipher_idx]
                                              : board_pkg::GLYPH_BLANK;

    // fast rotor position in hex, upper bit on its own digit
    assign o_hex4 = HEX_GLYPH[i_pos3[3:0]];
    assign o_hex5 = HEX_GLYPH[{3'b000, i_pos3[4]}];

    // spacers
    assign o_hex1 = board_pkg::GLYPH_BLANK;
    assign o_hex3 = board_pkg::GLYPH_BLANK;

endmodule

// ==== enigma_top.sv ====
`timescale 1ns/1ps

module enigma_top #(
    parameter int RELEASE_HOLD_CYCLES = 5000
) (
    input  logic                            CLOCK_50,
    input  logic                            i_reset,
    input  logic [7:0]                      i_scan_code,
    input  logic                            i_scan_valid,
    input  logic [board_pkg::SW_WIDTH-1:0]  i_sw,
    input  logic [board_pkg::KEY_WIDTH-1:0] i_key,
    output logic [7:0]                      o_cipher_ascii,
    output board_pkg::glyph_t               o_hex0,
    output board_pkg::glyph_t               o_hex1,
    output board_pkg::glyph_t               o_hex2,
    output board_pkg::glyph_t               o_hex3,
    output board_pkg::glyph_t               o_hex4,
    output board_pkg::glyph_t               o_hex5,
    output logic [4:0]                      o_led_select
);

    // operator settings
    enigma_pkg::letter_t start3;
    enigma_pkg::letter_t start2;
    enigma_pkg::letter_t start1;
    enigma_pkg::letter_t ring2;
    enigma_pkg::letter_t ring1;
    logic                reload;

    // keystroke side
    enigma_pkg::letter_t letter;
    logic                letter_ok;
    logic                rotate;
    enigma_pkg::letter_t cipher;

    // live rotor positions
    enigma_pkg::letter_t pos3;
    enigma_pkg::letter_t pos2;
    enigma_pkg::letter_t pos1;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    settings_control settings_control_inst (
        .i_clk        (CLOCK_50),
        .i_reset      (i_reset),
        .i_sw         (i_sw),
        .i_key        (i_key),
        .o_start3     (start3),
        .o_start2     (start2),
        .o_start1     (start1),
        .o_ring2      (ring2),
        .o_ring1      (ring1),
        .o_reload     (reload),
        .o_led_select (o_led_select)
    );

    keystroke_fsm #(
        .RELEASE_HOLD_CYCLES (RELEASE_HOLD_CYCLES)
    ) keystroke_fsm_inst (
        .i_clk          (CLOCK_50),
        .i_reset        (i_reset),
        .i_scan_code    (i_scan_code),
        .i_scan_valid   (i_scan_valid),
        .i_cipher       (cipher),
        .o_letter       (letter),
        .o_letter_ok    (letter_ok),
        .o_rotate       (rotate),
        .o_cipher_ascii (o_cipher_ascii)
    );

    rotor_stepper rotor_stepper_inst (
        .i_clk    (CLOCK_50),
        .i_reset  (i_reset),
        .i_rotate (rotate),
        .i_reload (reload),
        .i_start3 (start3),
        .i_start2 (start2),
        .i_start1 (start1),
        .o_pos3   (pos3),
        .o_pos2   (pos2),
        .o_pos1   (pos1)
    );

    // combinational, sampled in MAKE by the keystroke FSM
    cipher_path cipher_path_inst (
        .i_letter (letter),
        .i_pos3   (pos3),
        .i_pos2   (pos2),
        .i_pos1   (pos1),
        .i_ring2  (ring2),
        .i_ring1  (ring1),
        .o_cipher (cipher)
    );

    display_driver display_driver_inst (
        .i_letter       (letter),
        .i_letter_ok    (letter_ok),
        .i_cipher_ascii (o_cipher_ascii),
        .i_pos3         (pos3),
        .o_hex0         (o_hex0),
        .o_hex1         (o_hex1),
        .o_hex2         (o_hex2),
        .o_hex3         (o_hex3),
        .o_hex4         (o_hex4),
        .o_hex5         (o_hex5)
    );

endmodule

// ==== tb_enigma_model.svh ====
`ifndef TB_ENIGMA_MODEL_SVH
`define TB_ENIGMA_MODEL_SVH

// model state, letters held as ints 0 to 25
int m_start3, m_start2, m_start1;
int m_ring2, m_ring1;
int m_pos3, m_pos2, m_pos1;

// inverse wiring, built once from the forward tables
int m_inv [1:3][0:25];

function automatic int wrap26(input int v);
    return ((v % 26) + 26) % 26;
endfunction

task automatic model_reset();
    m_start3 = 0;
    m_start2 = 0;
    m_start1 = 0;
    m_ring2  = 0;
    m_ring1  = 0;
    m_pos3   = 0;
    m_pos2   = 0;
    m_pos1   = 0;
endtask

task automatic build_inverse();
    for (int r = 1; r <= 3; r++) begin
        for (int j = 0; j < 26; j++) begin
            m_inv[2'(r)][enigma_pkg::ROTOR_WIRING[2'(r)][5'(j)]] = j;
        end
    end
endtask

////////////////////////////////////////
// encryption
////////////////////////////////////////

// contact under the rotor is the letter shifted by the offset
function automatic int rotor_forward(input int r, input int x, input int off);
    return wrap26(int'(enigma_pkg::ROTOR_WIRING[2'(r)][5'(wrap26(x + off))]) - off);
endfunction

function automatic int rotor_backward(input int r, input int x, input int off);
    return wrap26(m_inv[2'(r)][5'(wrap26(x + off))] - off);
endfunction

function automatic int model_encrypt(input int letter);
    int off3;
    int off2;
    int off1;
    int x;
    // fast rotor keeps ring A
    off3 = m_pos3;
    off2 = wrap26(m_pos2 - m_ring2);
    off1 = wrap26(m_pos1 - m_ring1);
    x = rotor_forward(3, letter, off3);
    x = rotor_forward(2, x, off2);
    x = rotor_forward(1, x, off1);
    x = int'(enigma_pkg::REFLECTOR_WIRING[5'(x)]);
    x = rotor_backward(1, x, off1);
    x = rotor_backward(2, x, off2);
    x = rotor_backward(3, x, off3);
    return x;
endfunction

////////////////////////////////////////
// stepping and settings
////////////////////////////////////////

// notches looked at before anything moves
task automatic model_step();
    bit carry3;
    bit carry2;
    carry3 = (m_pos3 == int'(enigma_pkg::ROTOR_NOTCH[3]));
    carry2 = (m_pos2 == int'(enigma_pkg::ROTOR_NOTCH[2]));
    m_pos3 = wrap26(m_pos3 + 1);
    if (carry3 || carry2) begin
        m_pos2 = wrap26(m_pos2 + 1);
    end
    // middle rotor on its notch drags the slow one, the double step
    if (carry2) begin
        m_pos1 = wrap26(m_pos1 + 1);
    end
endtask

// field select, bit 0 start3 up to bit 4 start1
function automatic logic [4:0] select_for(input logic [9:0] w);
    return {w == board_pkg::SEL_START1, w == board_pkg::SEL_RING1,
            w == board_pkg::SEL_START2, w == board_pkg::SEL_RING2,
            w == board_pkg::SEL_START3};
endfunction

task automatic model_settings_press(input logic [9:0] w);
    logic [4:0] s;
    s = select_for(w);
    if (s[0]) m_start3 = wrap26(m_start3 + 1);
    if (s[1]) m_ring2 = wrap26(m_ring2 + 1);
    if (s[2]) m_start2 = wrap26(m_start2 + 1);
    if (s[3]) m_ring1 = wrap26(m_ring1 + 1);
    if (s[4]) m_start1 = wrap26(m_start1 + 1);
    // any accepted press reloads all positions
    if (|s) begin
        m_pos3 = m_start3;
        m_pos2 = m_start2;
        m_pos1 = m_start1;
    end
endtask

`endif

// ==== tb_enigma_top.sv ====
`timescale 1ns/1ps

module tb_enigma_top;

    localparam int HOLD            = 16;
    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int NUM_KEYS        = 300;
    localparam int WATCHDOG_CYCLES = NUM_KEYS * 40 + 2000;

    logic                            CLOCK_50;
    logic                            i_reset;
    logic [7:0]                      i_scan_code;
    logic                            i_scan_valid;
    logic [board_pkg::SW_WIDTH-1:0]  i_sw;
    logic [board_pkg::KEY_WIDTH-1:0] i_key;
    logic [7:0]                      o_cipher_ascii;
    board_pkg::glyph_t               o_hex0;
    board_pkg::glyph_t               o_hex1;
    board_pkg::glyph_t               o_hex2;
    board_pkg::glyph_t               o_hex3;
    board_pkg::glyph_t               o_hex4;
    board_pkg::glyph_t               o_hex5;
    logic [4:0]                      o_led_select;

    int          errors;
    int          checks;
    logic [31:0] rng_state;
    int          letter;

    // keyboard set 2 make codes, A to Z
    localparam logic [7:0] SCAN_OF_LETTER [0:25] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };

    // active low digits 0 to F, segment a in bit 0
    localparam logic [6:0] HEX_DIGIT [0:15] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
    };

    // active low letter shapes A to Z, K M W X approximate
    localparam logic [6:0] LETTER_SHAPE [0:25] = '{
        7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E, 7'h42,
        7'h09, 7'h4F, 7'h61, 7'h0A, 7'h47, 7'h6A, 7'h2B,
        7'h23, 7'h0C, 7'h18, 7'h2F, 7'h12, 7'h07, 7'h41,
        7'h63, 7'h55, 7'h09, 7'h11, 7'h24
    };

    `include "tb_enigma_model.svh"

    enigma_top #(
        .RELEASE_HOLD_CYCLES (HOLD)
    ) enigma_top_inst (
        .CLOCK_50       (CLOCK_50),
        .i_reset        (i_reset),
        .i_scan_code    (i_scan_code),
        .i_scan_valid   (i_scan_valid),
        .i_sw           (i_sw),
        .i_key          (i_key),
        .o_cipher_ascii (o_cipher_ascii),
        .o_hex0         (o_hex0),
        .o_hex1         (o_hex1),
        .o_hex2         (o_hex2),
        .o_hex3         (o_hex3),
        .o_hex4         (o_hex4),
        .o_hex5         (o_hex5),
        .o_led_select   (o_led_select)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    // bound on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % 32'(n));
    endfunction

    function automatic bit is_letter_code(input logic [7:0] c);
        bit hit;
        hit = 1'b0;
        for (int j = 0; j < 26; j++) begin
            if (SCAN_OF_LETTER[5'(j)] == c) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // inputs change just after the rising edge
    task automatic tick();
        @(posedge CLOCK_50);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] code);
        i_scan_code  = code;
        i_scan_valid = 1'b1;
        tick();
        i_scan_valid = 1'b0;
    endtask

    task automatic check_fast_rotor();
        check("o_hex4", 32'(o_hex4), 32'(HEX_DIGIT[4'(m_pos3 % 16)]));
        check("o_hex5", 32'(o_hex5), 32'(HEX_DIGIT[4'(m_pos3 / 16)]));
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // make, repeats, break, maybe a stray release, then the real release
    task automatic keystroke(input logic [7:0] code, input bit is_letter, input int ltr);
        int         exp_letter;
        int         exp_ascii;
        int         repeats;
        logic [6:0] exp_plain;
        logic [6:0] exp_shown;
        exp_letter = model_encrypt(ltr);
        exp_ascii  = is_letter ? exp_letter + int'(enigma_pkg::ASCII_A) : 0;
        // digits shown while the key is down
        exp_plain  = is_letter ? LETTER_SHAPE[5'(ltr)] : board_pkg::GLYPH_BLANK;
        exp_shown  = is_letter ? LETTER_SHAPE[5'(exp_letter)] : board_pkg::GLYPH_BLANK;
        send_byte(code);
        check("o_cipher_ascii", 32'(o_cipher_ascii), 32'h0);
        tick();
        check("o_cipher_ascii", 32'(o_cipher_ascii), 32'(exp_ascii));
        check("o_hex0", 32'(o_hex0), 32'(exp_plain));
        check("o_hex2", 32'(o_hex2), 32'(exp_shown));
        repeats = rand_below(3);
        for (int r = 0; r < repeats; r++) begin
            send_byte(code);
            check("o_cipher_ascii", 32'(o_cipher_ascii), 32'(exp_ascii));
        end
        send_byte(board_pkg::BREAK_CODE);
        check("o_cipher_ascii", 32'(o_cipher_ascii), 32'h0);
        // release of another key leaves the held one pending
        if (rand_below(2) == 1) begin
            send_byte(code ^ 8'(1 + rand_below(255)));
            check("o_cipher_ascii", 32'(o_cipher_ascii), 32'h0);
        end
        send_byte(code);
        if (is_letter) model_step();
        repeat (HOLD + 1) tick();
        check_fast_rotor();
        check("o_cipher_ascii", 32'(o_cipher_ascii), 32'h0);
        check("o_hex2", 32'(o_hex2), 32'(board_pkg::GLYPH_BLANK));
    endtask

    function automatic logic [7:0] pick_nonletter();
        logic [7:0] c;
        do begin
            c = 8'(next_rand());
        end while (is_letter_code(c) || c == board_pkg::BREAK_CODE);
        return c;
    endfunction

    // mostly select codes, some rotor-number codes and noise words
    function automatic logic [9:0] pick_switch_word();
        int         kind;
        logic [9:0] w;
        kind = rand_below(4);
        if (kind < 2) begin
            case (rand_below(5))
                0:       w = board_pkg::SEL_START3;
                1:       w = board_pkg::SEL_RING2;
                2:       w = board_pkg::SEL_START2;
                3:       w = board_pkg::SEL_RING1;
                default: w = board_pkg::SEL_START1;
            endcase
        end else if (kind == 2) begin
            w = 10'b1 << (1 + 3 * rand_below(3));
        end else begin
            w = 10'(next_rand());
        end
        return w;
    endfunction

    task automatic settings_press(input logic [9:0] word);
        i_sw = word;
        repeat (2) tick();
        check("o_led_select", 32'(o_led_select), 32'(select_for(word)));
        // sync, edge detect, count, reload
        i_key[3] = 1'b0;
        repeat (4) tick();
        model_settings_press(word);
        i_key[3] = 1'b1;
        repeat (3) tick();
        check_fast_rotor();
        i_sw = '0;
    endtask

    initial begin
        i_reset      = 1'b1;
        i_scan_code  = 8'h00;
        i_scan_valid = 1'b0;
        i_sw         = '0;
        i_key        = '1;
        errors       = 0;
        checks       = 0;
        rng_state    = 32'hc81a4cf3;
        model_reset();
        build_inverse();

        repeat (8) @(posedge CLOCK_50);
        #DRIVE_DELAY;
        i_reset = 1'b0;
        tick();

        // reset state
        check("o_cipher_ascii", 32'(o_cipher_ascii), 32'h0);
        check_fast_rotor();
        check("o_hex2", 32'(o_hex2), 32'(board_pkg::GLYPH_BLANK));
        check("o_hex1", 32'(o_hex1), 32'(board_pkg::GLYPH_BLANK));
        check("o_hex3", 32'(o_hex3), 32'(board_pkg::GLYPH_BLANK));

        for (int k = 0; k < NUM_KEYS; k++) begin
            if (rand_below(4) == 0) settings_press(pick_switch_word());
            if (rand_below(8) == 0) keystroke(pick_nonletter(), 1'b0, 0);
            letter = rand_below(26);
            keystroke(SCAN_OF_LETTER[5'(letter)], 1'b1, letter);
        end

        $display("keystrokes: %0d, checks: %0d, errors: %0d", NUM_KEYS, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
enigma_pkg.sv
board_pkg.sv
settings_control.sv
keystroke_fsm.sv
rotor_stepper.sv
cipher_path.sv
display_driver.sv
enigma_top.sv
tb_enigma_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module tb_enigma_top -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir
